// File: Makefile
# Verilator build and run of the tanh unit testbench

VERILATOR ?= verilator
TOP       ?= tb_tanh_top
FILELIST  ?= tanh_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Checks failed
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/1ps

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation, search $(LOG) for failure"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG FAIL_MSG VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi; \
	if [ $$status -ne 0 ]; then \
		echo "simulation exited with status $$status"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: pwl_mac_if.sv
`timescale 1ns/1ps
`default_nettype none

interface pwl_mac_if;

	logic valid;
	logic [tanh_pkg::DATA_W-1:0] mag;       // unsigned Q10
	logic [tanh_pkg::COEF_W-1:0] slope;
	logic [tanh_pkg::ADDEND_W-1:0] addend;  // already in Q21

	modport src (
		output valid,
		output mag,
		output slope,
		output addend
	);

	modport dst (
		input valid,
		input mag,
		input slope,
		input addend
	);

endinterface

`default_nettype wire

// File: tanh_core.sv
`timescale 1ns/1ps
`default_nettype none

module tanh_core (
	input  logic clk,
	input  logic reset,
	input  logic i_valid,
	input  logic i_ready,
	input  logic [tanh_pkg::DATA_W-1:0] i_x,
	output logic o_valid,
	output logic o_ready,
	output logic [tanh_pkg::DATA_W-1:0] o_y
);

	logic in_valid_q;
	logic [tanh_pkg::DATA_W-1:0] x_q;
	logic mag_valid;
	logic [tanh_pkg::DATA_W-1:0] mag;
	logic mag_negative;
	logic negative_d1;
	logic negative_d2;
	logic acc_valid;
	logic signed [tanh_pkg::ACC_W-1:0] acc;
	logic signed [tanh_pkg::ACC_W-1:0] signed_acc;
	logic round_valid;
	logic signed [tanh_pkg::ACC_W-1:0] round_value;
	logic out_valid_q;
	logic [tanh_pkg::DATA_W-1:0] y_q;

	pwl_mac_if mac_bus ();

	// ##########################################################
	// input register and sign delay
	// ##########################################################
	always_ff @(posedge clk) begin
		if (reset) begin
			in_valid_q <= 1'b0;
			x_q <= '0;
			negative_d1 <= 1'b0;
			negative_d2 <= 1'b0;
		end else if (i_ready) begin
			in_valid_q <= i_valid;
			x_q <= i_x;
			negative_d1 <= mag_negative;   // lines up with the mac result
			negative_d2 <= negative_d1;
		end
	end

	tanh_magnitude u_magnitude (
		.clk        (clk),
		.reset      (reset),
		.i_enable   (i_ready),
		.i_valid    (in_valid_q),
		.i_x        (x_q),
		.o_valid    (mag_valid),
		.o_mag      (mag),
		.o_negative (mag_negative)
	);

	tanh_segment_select u_segment_select (
		.i_valid (mag_valid),
		.i_mag   (mag),
		.mac     (mac_bus)
	);

	tanh_mac u_mac (
		.clk      (clk),
		.reset    (reset),
		.i_enable (i_ready),
		.op       (mac_bus),
		.o_valid  (acc_valid),
		.o_acc    (acc)
	);

	// exact negation keeps tanh odd
	assign signed_acc = negative_d2 ? -acc : acc;

	tanh_round u_round (
		.clk      (clk),
		.reset    (reset),
		.i_enable (i_ready),
		.i_valid  (acc_valid),
		.i_acc    (signed_acc),
		.o_valid  (round_valid),
		.o_value  (round_value)
	);

	// ##########################################################
	// output register
	// ##########################################################
	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid_q <= 1'b0;
			y_q <= '0;
		end else if (i_ready) begin
			out_valid_q <= round_valid;
			y_q <= round_value[tanh_pkg::DATA_W-1:0];   // back to Q8.10
		end
	end

	assign o_y = y_q;
	assign o_ready = i_ready;
	assign o_valid = out_valid_q & i_ready;

	// output value and the rounding stage feeding it both freeze
	assert property (@(posedge clk) disable iff (reset)
		!i_ready |=> $stable(y_q) && $stable(round_valid) && $stable(round_value))
		else $error("tanh_core: o_y or its source changed while i_ready low");

endmodule

`default_nettype wire

// File: tanh_mac.sv
`timescale 1ns/1ps
`default_nettype none

module tanh_mac (
	input  logic clk,
	input  logic reset,
	input  logic i_enable,
	pwl_mac_if.dst op,
	output logic o_valid,
	output logic signed [tanh_pkg::ACC_W-1:0] o_acc
);

	logic op_valid_q;
	logic [tanh_pkg::DATA_W-1:0] mag_q;
	logic [tanh_pkg::COEF_W-1:0] slope_q;
	logic [tanh_pkg::ADDEND_W-1:0] addend_q;
	logic acc_valid_q;
	logic signed [tanh_pkg::ACC_W-1:0] acc_q;

	// ##########################################################
	// operand register
	// ##########################################################
	always_ff @(posedge clk) begin
		if (reset) begin
			op_valid_q <= 1'b0;
			mag_q <= '0;
			slope_q <= '0;
			addend_q <= '0;
		end else if (i_enable) begin
			op_valid_q <= op.valid;
			mag_q <= op.mag;
			slope_q <= op.slope;
			addend_q <= op.addend;
		end
	end

	// ##########################################################
	// product plus addend
	// ##########################################################
	always_ff @(posedge clk) begin
		if (reset) begin
			acc_valid_q <= 1'b0;
			acc_q <= '0;
		end else if (i_enable) begin
			acc_valid_q <= op_valid_q;
			acc_q <= tanh_pkg::ACC_W'(mag_q) * tanh_pkg::ACC_W'(slope_q)
				+ tanh_pkg::ACC_W'(addend_q);         // Q10 x Q11 -> Q21
		end
	end

	assign o_valid = acc_valid_q;
	assign o_acc = acc_q;

	assert property (@(posedge clk) disable iff (reset)
		o_valid |-> !$isunknown(o_acc))
		else $error("tanh_mac: o_acc unknown while o_valid high");

endmodule

`default_nettype wire

// File: tanh_magnitude.sv
`timescale 1ns/1ps
`default_nettype none

module tanh_magnitude (
	input  logic clk,
	input  logic reset,
	input  logic i_enable,
	input  logic i_valid,
	input  logic [tanh_pkg::DATA_W-1:0] i_x,
	output logic o_valid,
	output logic [tanh_pkg::DATA_W-1:0] o_mag,
	output logic o_negative
);

	logic is_negative;
	logic [tanh_pkg::DATA_W-1:0] abs_x;
	logic valid_q;
	logic [tanh_pkg::DATA_W-1:0] mag_q;
	logic negative_q;

	assign is_negative = i_x[tanh_pkg::DATA_W-1];

	// most negative value maps to 2^17 as unsigned
	assign abs_x = is_negative ? -i_x : i_x;

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= 1'b0;
			mag_q <= '0;
			negative_q <= 1'b0;
		end else if (i_enable) begin
			valid_q <= i_valid;
			mag_q <= abs_x;
			negative_q <= is_negative;
		end
	end

	assign o_valid = valid_q;
	assign o_mag = mag_q;
	assign o_negative = negative_q;

endmodule

`default_nettype wire

// File: tanh_pkg.sv
`default_nettype none

package tanh_pkg;

	// ##########################################################
	// widths and fixed-point formats
	// ##########################################################
	localparam int DATA_W = 18;             // Q8.10 sample
	localparam int FRAC_W = 10;
	localparam int COEF_W = 13;             // unsigned Q2.11
	localparam int ACC_W = 32;              // signed Q21
	localparam int INTERCEPT_SHIFT = 10;    // Q11 -> Q21
	localparam int ROUND_SHIFT = 11;        // Q21 -> Q10
	localparam int ADDEND_W = COEF_W + INTERCEPT_SHIFT;

	// ##########################################################
	// segmentation
	// ##########################################################
	localparam int SEG_COUNT = 32;
	localparam int SEG_IDX_W = $clog2(SEG_COUNT);
	localparam int SEG_SHIFT = 7;           // 0.125 per segment
	localparam int SAT_LIMIT = 4 << FRAC_W; // 4.0
	localparam int ONE_ACC = 1 << (FRAC_W + ROUND_SHIFT);

	// enabled edges from accepted input to o_valid
	localparam int PIPE_LATENCY = 7;

	// slope per segment in Q2.11
	localparam logic [COEF_W-1:0] SEG_SLOPE [SEG_COUNT] = '{
		13'b0011111110101, 13'b0011110110111, 13'b0011101000011, 13'b0011010100100,
		13'b0010111101011, 13'b0010100101000, 13'b0010001100111, 13'b0001110110001,
		13'b0001100001110, 13'b0001001111111, 13'b0001000000101, 13'b0000110011111,
		13'b0000101001011, 13'b0000100000111, 13'b0000011010000, 13'b0000010100100,
		13'b0000010000001, 13'b0000001100101, 13'b0000001001111, 13'b0000000111110,
		13'b0000000110000, 13'b0000000100110, 13'b0000000011101, 13'b0000000010111,
		13'b0000000010010, 13'b0000000001110, 13'b0000000001011, 13'b0000000001000,
		13'b0000000000111, 13'b0000000000101, 13'b0000000000100, 13'b0000000000011
	};

	// intercept per segment in Q2.11
	localparam logic [COEF_W-1:0] SEG_INTERCEPT [SEG_COUNT] = '{
		13'b0000000000000, 13'b0000000001000, 13'b0000000100101, 13'b0000001100000,
		13'b0000010111101, 13'b0000100110111, 13'b0000111001000, 13'b0001001100111,
		13'b0001100001010, 13'b0001110101011, 13'b0010001000011, 13'b0010011001111,
		13'b0010101001101, 13'b0010110111100, 13'b0011000011101, 13'b0011001101111,
		13'b0011010110101, 13'b0011011110000, 13'b0011100100001, 13'b0011101001010,
		13'b0011101101100, 13'b0011110001000, 13'b0011110011110, 13'b0011110110001,
		13'b0011111000000, 13'b0011111001101, 13'b0011111010111, 13'b0011111011111,
		13'b0011111100101, 13'b0011111101010, 13'b0011111101111, 13'b0011111110010
	};

endpackage

`default_nettype wire

// File: tanh_round.sv
`timescale 1ns/1ps
`default_nettype none

module tanh_round (
	input  logic clk,
	input  logic reset,
	input  logic i_enable,
	input  logic i_valid,
	input  logic signed [tanh_pkg::ACC_W-1:0] i_acc,
	output logic o_valid,
	output logic signed [tanh_pkg::ACC_W-1:0] o_value
);

	logic stage_valid_q;
	logic signed [tanh_pkg::ACC_W-1:0] floor_q;
	logic signed [tanh_pkg::ACC_W-1:0] ceil_q;
	logic round_up_q;
	logic valid_q;
	logic signed [tanh_pkg::ACC_W-1:0] value_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			stage_valid_q <= 1'b0;
			floor_q <= '0;
			ceil_q <= '0;
			round_up_q <= 1'b0;
			valid_q <= 1'b0;
			value_q <= '0;
		end else if (i_enable) begin
			stage_valid_q <= i_valid;
			floor_q <= i_acc >>> tanh_pkg::ROUND_SHIFT;
			ceil_q <= (i_acc >>> tanh_pkg::ROUND_SHIFT) + 1;
			round_up_q <= i_acc[tanh_pkg::ROUND_SHIFT-1];   // half lsb of Q10
			valid_q <= stage_valid_q;
			value_q <= round_up_q ? ceil_q : floor_q;
		end
	end

	assign o_valid = valid_q;
	assign o_value = value_q;

	// two enabled edges in a row carry i_valid through to o_valid
	assert property (@(posedge clk) disable iff (reset)
		$past(i_enable) && $past(i_enable, 2) && !$past(reset) && !$past(reset, 2)
		|-> o_valid == $past(i_valid, 2))
		else $error("tanh_round: o_valid does not follow i_valid by two edges");

endmodule

`default_nettype wire

// File: tanh_segment_select.sv
`timescale 1ns/1ps
`default_nettype none

module tanh_segment_select (
	input  logic i_valid,
	input  logic [tanh_pkg::DATA_W-1:0] i_mag,
	pwl_mac_if.src mac
);

	logic saturate;
	logic [tanh_pkg::SEG_IDX_W-1:0] seg_idx;
	logic [tanh_pkg::COEF_W-1:0] seg_slope;
	logic [tanh_pkg::COEF_W-1:0] seg_intercept;

	assign saturate = i_mag >= tanh_pkg::SAT_LIMIT;

	// only meaningful below the saturation limit
	assign seg_idx = tanh_pkg::SEG_IDX_W'(i_mag >> tanh_pkg::SEG_SHIFT);

	assign seg_slope = tanh_pkg::SEG_SLOPE[seg_idx];
	assign seg_intercept = tanh_pkg::SEG_INTERCEPT[seg_idx];

	always_comb begin
		mac.valid = i_valid;
		mac.mag = i_mag;
		if (saturate) begin
			mac.slope = '0;                                   // flat at 1.0
			mac.addend = tanh_pkg::ADDEND_W'(tanh_pkg::ONE_ACC);
		end else begin
			mac.slope = seg_slope;
			mac.addend = tanh_pkg::ADDEND_W'(seg_intercept) << tanh_pkg::INTERCEPT_SHIFT;
		end
	end

endmodule

`default_nettype wire

// File: tanh_top.f
tanh_pkg.sv
pwl_mac_if.sv
tanh_magnitude.sv
tanh_segment_select.sv
tanh_mac.sv
tanh_round.sv
tanh_core.sv
tanh_top.sv
tb_tanh_top.sv

// File: tanh_top.sv
`timescale 1ns/1ps
`default_nettype none

module tanh_top (
	input  logic clk,
	input  logic reset,
	input  logic i_valid,
	input  logic i_ready,
	input  logic [tanh_pkg::DATA_W-1:0] i_x,
	output logic o_valid,
	output logic o_ready,
	output logic [tanh_pkg::DATA_W-1:0] o_y
);

	logic core_valid;
	logic core_ready;
	logic [tanh_pkg::DATA_W-1:0] core_y;

	tanh_core u_core (
		.clk     (clk),
		.reset   (reset),
		.i_valid (i_valid),
		.i_ready (i_ready),
		.i_x     (i_x),
		.o_valid (core_valid),
		.o_ready (core_ready),
		.o_y     (core_y)
	);

	assign o_valid = core_valid;
	assign o_ready = core_ready;
	assign o_y = core_y;

endmodule

`default_nettype wire

// File: tb_tanh_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tanh_top;

	localparam int CLK_PERIOD = 40;
	localparam int SEED = 50;
	localparam int RANDOM_COUNT = 300;
	localparam int SWEEP_COUNT = 200;
	localparam int SAMPLE_TOTAL = 33 + 33 + 8 + RANDOM_COUNT + SWEEP_COUNT;
	localparam int CYCLE_LIMIT = SAMPLE_TOTAL * 2 + 200;
	localparam real Q_SCALE = real'(1 << tanh_pkg::FRAC_W);

	logic clk;
	logic reset;
	logic i_valid;
	logic i_ready;
	logic [tanh_pkg::DATA_W-1:0] i_x;
	logic o_valid;
	logic o_ready;
	logic [tanh_pkg::DATA_W-1:0] o_y;

	logic [tanh_pkg::DATA_W-1:0] expected_q [$];
	logic [tanh_pkg::DATA_W-1:0] input_q [$];
	int accept_edge_q [$];
	bit accuracy_q [$];
	bit accuracy_mode;
	int enabled_edges;
	int cycle_count;
	int accepted_count;
	int received_count;
	int value_errors;
	int order_errors;
	int flow_errors;

	tanh_top u_dut (
		.clk     (clk),
		.reset   (reset),
		.i_valid (i_valid),
		.i_ready (i_ready),
		.i_x     (i_x),
		.o_valid (o_valid),
		.o_ready (o_ready),
		.o_y     (o_y)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ############################################################
	// reference model
	// ############################################################
	function automatic int to_int(input logic [tanh_pkg::DATA_W-1:0] v);
		return int'($signed(v));
	endfunction

	function automatic logic [tanh_pkg::DATA_W-1:0] model_tanh(
		input logic [tanh_pkg::DATA_W-1:0] x);
		bit negative;
		int mag;
		int idx;
		longint acc;
		longint rounded;
		negative = x[tanh_pkg::DATA_W-1];
		mag = negative ? -to_int(x) : to_int(x);
		if (mag >= tanh_pkg::SAT_LIMIT) begin
			acc = longint'(tanh_pkg::ONE_ACC);
		end else begin
			idx = mag / (1 << tanh_pkg::SEG_SHIFT);   // 0.125 wide segments
			acc = longint'(mag) * longint'(tanh_pkg::SEG_SLOPE[idx])
				+ (longint'(tanh_pkg::SEG_INTERCEPT[idx]) << tanh_pkg::INTERCEPT_SHIFT);
		end
		if (negative)
			acc = -acc;
		rounded = (acc >>> tanh_pkg::ROUND_SHIFT) + longint'(acc[tanh_pkg::ROUND_SHIFT-1]);
		return rounded[tanh_pkg::DATA_W-1:0];
	endfunction

	function automatic int real_tanh_q10(input logic [tanh_pkg::DATA_W-1:0] x);
		real t;
		t = $tanh($itor(to_int(x)) / Q_SCALE) * Q_SCALE;
		return (t >= 0.0) ? $rtoi(t + 0.5) : $rtoi(t - 0.5);
	endfunction

	function automatic logic [tanh_pkg::DATA_W-1:0] in_range_sample();
		return tanh_pkg::DATA_W'(int'($urandom() % 8191) - 4095);   // below 4.0
	endfunction

	function automatic logic [tanh_pkg::DATA_W-1:0] random_sample();
		if ($urandom() % 2)
			return tanh_pkg::DATA_W'($urandom());
		return in_range_sample();
	endfunction

	// ############################################################
	// scoreboard on the rising clock edge
	// ############################################################
	task automatic check_output();
		logic [tanh_pkg::DATA_W-1:0] exp_y;
		logic [tanh_pkg::DATA_W-1:0] x;
		int latency;
		int ref_y;
		received_count++;
		assert (expected_q.size() != 0) else begin
			order_errors++;
			$display("o_valid high at %0t with no sample in flight", $time);
		end
		if (expected_q.size() != 0) begin
			exp_y = expected_q.pop_front();
			x = input_q.pop_front();
			latency = enabled_edges - accept_edge_q.pop_front();
			assert (o_y == exp_y) else begin
				value_errors++;
				$display("Error at %0t: o_y for i_x %0d expected %0d, got %0d",
					$time, to_int(x), to_int(exp_y), to_int(o_y));
			end
			assert (latency == tanh_pkg::PIPE_LATENCY) else begin
				order_errors++;
				$display("Error at %0t: o_valid latency expected %0d, got %0d",
					$time, tanh_pkg::PIPE_LATENCY, latency);
			end
			if (accuracy_q.pop_front()) begin
				ref_y = real_tanh_q10(x);
				assert (to_int(o_y) - ref_y <= 3 && ref_y - to_int(o_y) <= 3) else begin
					value_errors++;
					$display("Error at %0t: o_y for i_x %0d expected %0d +-3, got %0d",
						$time, to_int(x), ref_y, to_int(o_y));
				end
			end
		end
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (!reset) begin
			if (i_ready)
				enabled_edges = enabled_edges + 1;
			if (i_valid && i_ready) begin   // accepted on this edge
				expected_q.push_back(model_tanh(i_x));
				input_q.push_back(i_x);
				accept_edge_q.push_back(enabled_edges);
				accuracy_q.push_back(accuracy_mode);
				accepted_count++;
			end
			if (o_valid)
				check_output();
		end
	end

	always @(negedge clk) begin
		if (!reset) begin
			assert (!(o_valid && !i_ready)) else begin
				flow_errors++;
				$display("Error at %0t: o_valid expected 0 while i_ready low, got %0b",
					$time, o_valid);
			end
			assert (o_ready == i_ready) else begin
				flow_errors++;
				$display("Error at %0t: o_ready expected %0b, got %0b", $time, i_ready, o_ready);
			end
		end
	end

	// ############################################################
	// stimulus and tests
	// ############################################################
	task automatic drive_cycle(input bit valid, input logic [tanh_pkg::DATA_W-1:0] x,
		input bit ready);
		@(posedge clk);
		i_valid <= valid;
		i_x <= x;
		i_ready <= ready;
	endtask

	task automatic drain();
		drive_cycle(1'b0, '0, 1'b1);
		@(negedge clk);
		while (expected_q.size() != 0) begin
			drive_cycle(1'b0, '0, 1'b1);
			@(negedge clk);
		end
	endtask

	task automatic idle_after_reset();
		repeat (12) begin
			drive_cycle(1'b0, '0, 1'($urandom() % 2));
			@(negedge clk);
			assert (o_valid == 1'b0) else begin
				flow_errors++;
				$display("Error at %0t: o_valid expected 0, got %0b", $time, o_valid);
			end
		end
	endtask

	task automatic segment_boundaries(input bit negate);
		for (int k = 0; k < tanh_pkg::SEG_COUNT; k++)
			drive_cycle(1'b1, tanh_pkg::DATA_W'(negate ? -(k * 128) : k * 128), 1'b1);
		drive_cycle(1'b1, tanh_pkg::DATA_W'(negate ? -4095 : 4095), 1'b1);   // just under 4.0
		drain();
	endtask

	task automatic saturation();
		int sat_values [8] = '{4096, 4097, 6000, 131071, -4096, -4097, -9000, -131072};
		foreach (sat_values[i])
			drive_cycle(1'b1, tanh_pkg::DATA_W'(sat_values[i]), 1'b1);
		drain();
	endtask

	task automatic random_flow();
		int sent;
		bit valid;
		bit ready;
		sent = 0;
		while (sent < RANDOM_COUNT) begin
			ready = ($urandom() % 4) != 0;
			valid = ($urandom() % 4) != 0;
			drive_cycle(valid, random_sample(), ready);
			if (valid && ready)
				sent++;
		end
		drain();
		assert (accepted_count == received_count) else begin
			order_errors++;
			$display("%0d samples accepted but %0d results received",
				accepted_count, received_count);
		end
	endtask

	task automatic accuracy_sweep();
		accuracy_mode = 1'b1;
		repeat (SWEEP_COUNT)
			drive_cycle(1'b1, in_range_sample(), 1'b1);
		drain();
		accuracy_mode = 1'b0;
	endtask

	initial begin
		wait (cycle_count >= CYCLE_LIMIT);
		$display("run stopped after %0d cycles before the tests finished", cycle_count);
		$display("Checks failed");
		$finish;
	end

	initial begin
		void'($urandom(SEED));
		reset = 1'b1;
		i_valid = 1'b0;
		i_ready = 1'b1;
		i_x = '0;
		cycle_count = 0;
		accuracy_mode = 1'b0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		idle_after_reset();
		segment_boundaries(1'b0);
		segment_boundaries(1'b1);   // odd symmetry
		saturation();
		random_flow();
		accuracy_sweep();
		$display("errors: %0d value, %0d order, %0d flow", value_errors, order_errors,
			flow_errors);
		if (value_errors + order_errors + flow_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire
